//--- hdl/lumi_pkg.sv
`default_nettype none

package lumi_pkg;

   //##############################
   // widths that carry a meaning
   //##############################
   typedef logic [7:0]  reg_addr_t;   // register byte address
   typedef logic [31:0] reg_data_t;   // register data word
   typedef logic [7:0]  iow_t;        // pad width code, 2**n bytes
   typedef logic [15:0] crdt_t;       // credit count / interval
   typedef logic [31:0] cycles_t;     // perf cycle count
   typedef logic [1:0]  arbmode_t;    // crossbar arbitration mode

   //##############################
   // register address map
   //##############################
   localparam reg_addr_t LUMI_CTRL          = 8'h00;
   localparam reg_addr_t LUMI_STATUS        = 8'h04;   // read only
   localparam reg_addr_t LUMI_TXMODE        = 8'h08;
   localparam reg_addr_t LUMI_RXMODE        = 8'h0C;
   localparam reg_addr_t LUMI_CRDTINIT      = 8'h10;
   localparam reg_addr_t LUMI_CRDTINTRVL    = 8'h14;
   localparam reg_addr_t LUMI_REQSTALLCYC   = 8'h18;
   localparam reg_addr_t LUMI_RESPSTALLCYC  = 8'h1C;
   localparam reg_addr_t LUMI_REQACTIVECYC  = 8'h20;
   localparam reg_addr_t LUMI_RESPACTIVECYC = 8'h24;

   //##############################
   // credits
   //##############################
   localparam int    CRDT_DEPTH      = 5;   // rx fifo depth
   localparam int    NFIFO           = 8;   // parallel rx fifos
   localparam crdt_t TOT_CRDT        = crdt_t'(CRDT_DEPTH * NFIFO);
   localparam crdt_t CRDT_INTRVL_RST = 16'd16;   // default update interval

   // saturation point of the perf counters
   localparam cycles_t CYCLES_MAX = '1;

endpackage

`default_nettype wire

//--- hdl/lumi_reg_bus_if.sv
`default_nettype none

// internal register bus, strobes plus a combinational read path
interface lumi_reg_bus_if
   import lumi_pkg::*;
();

   logic      write;   // write strobe, one cycle
   logic      read;    // read strobe, one cycle
   reg_addr_t addr;    // valid with either strobe
   reg_data_t wdata;
   reg_data_t rdata;   // comb from addr

   // front end side
   modport host (
      output write, read, addr, wdata,
      input  rdata
   );

   // register file side
   modport target (
      input  write, addr, wdata,
      output rdata
   );

endinterface

`default_nettype wire

//--- hdl/lumi_regif.sv
`default_nettype none

module lumi_regif
   import lumi_pkg::*;
(
   input  wire            clk,
   input  wire            nreset,
   // request side
   input  wire            req_valid,
   input  wire            req_write,   // 1 = write, 0 = read
   input  wire reg_addr_t req_addr,
   input  wire reg_data_t req_wdata,
   output logic           req_ready,
   // response side, reads only
   output logic           resp_valid,
   output reg_data_t      resp_data,
   input  wire            resp_ready,
   // register bus
   lumi_reg_bus_if.host   bus
);

   logic req_fire;   // request handshake

   // one read in flight at most, also stall while its strobe is out
   assign req_ready = ~(resp_valid | bus.read);
   assign req_fire  = req_valid & req_ready;

   //##############################
   // request to strobes
   //##############################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         bus.write <= 1'b0;
         bus.read  <= 1'b0;
      end
      else
      begin
         bus.write <= req_fire & req_write;
         bus.read  <= req_fire & ~req_write;
      end
   end

   // addr and data line up with the strobes
   always_ff @(posedge clk)
   begin
      if (req_fire)
      begin
         bus.addr  <= req_addr;
         bus.wdata <= req_wdata;
      end
   end

   //##############################
   // held read response
   //##############################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         resp_valid <= 1'b0;
      else if (bus.read)
         resp_valid <= 1'b1;   // new response
      else if (resp_ready)
         resp_valid <= 1'b0;   // taken
   end

   // capture mux output with the strobe, stays put until taken
   always_ff @(posedge clk)
   begin
      if (bus.read)
         resp_data <= bus.rdata;
   end

endmodule

`default_nettype wire

//--- hdl/lumi_crdt_monitor.sv
`default_nettype none

module lumi_crdt_monitor
   import lumi_pkg::*;
(
   input  wire     clk,
   input  wire     nreset,
   input  wire     pending,      // class has a packet waiting
   input  wire     crdt_avail,   // far side has credit for it
   input  wire     enable,       // tx enabled
   output cycles_t stall_cycles,
   output cycles_t active_cycles
);

   logic count_stall;
   logic count_active;

   // only cycles with traffic waiting are counted
   assign count_stall  = enable & pending & ~crdt_avail;
   assign count_active = enable & pending & crdt_avail;

   // no credit, packet stuck
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         stall_cycles <= '0;
      else if (count_stall && (stall_cycles != CYCLES_MAX))
         stall_cycles <= stall_cycles + 1'b1;   // sticks at all ones
   end

   // credit there, packet moving
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         active_cycles <= '0;
      else if (count_active && (active_cycles != CYCLES_MAX))
         active_cycles <= active_cycles + 1'b1;
   end

endmodule

`default_nettype wire

//--- hdl/lumi_regs.sv
`default_nettype none

module lumi_regs
   import lumi_pkg::*;
(
   input  wire            clk,
   input  wire            nreset,
   input  wire            devicemode,      // 1 = device side
   input  wire            deviceready,     // from brick controller
   // phy status
   input  wire            phy_linkactive,
   input  wire iow_t      phy_iow,
   // register bus
   lumi_reg_bus_if.target bus,
   // perf counts from the monitors
   input  wire cycles_t   req_stall_cycles,
   input  wire cycles_t   resp_stall_cycles,
   input  wire cycles_t   req_active_cycles,
   input  wire cycles_t   resp_active_cycles,
   // controls out
   output logic           host_linkactive,
   output arbmode_t       csr_arbmode,
   output logic           csr_txen,
   output logic           csr_txcrdt_en,
   output logic           csr_rxen,
   output iow_t           csr_txiowidth,
   output iow_t           csr_rxiowidth,
   output crdt_t          csr_txcrdt_intrvl,
   output crdt_t          csr_rxcrdt_req_init,
   output crdt_t          csr_rxcrdt_resp_init
);

   logic      linkactive;
   logic      linkactive_d;
   logic      linkactive_rise;   // one cycle pulse

   reg_data_t ctrl_reg;
   reg_data_t txmode_reg;
   reg_data_t rxmode_reg;
   reg_data_t crdt_init_reg;     // {resp, req}
   crdt_t     crdt_intrvl_reg;

   logic      write_ctrl;
   logic      write_txmode;
   logic      write_rxmode;
   logic      write_crdt_init;
   logic      write_crdt_intrvl;

   //##############################
   // link active tracking
   //##############################
   // device side waits for the brick to be ready, host follows the phy
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         linkactive <= 1'b0;
      else if (!devicemode || deviceready)
         linkactive <= phy_linkactive;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         linkactive_d    <= 1'b0;
         linkactive_rise <= 1'b0;
      end
      else
      begin
         linkactive_d    <= linkactive;
         linkactive_rise <= linkactive & ~linkactive_d;
      end
   end

   assign host_linkactive = linkactive;

   // write decode, word aligned
   assign write_ctrl        = bus.write & (bus.addr[7:2] == LUMI_CTRL[7:2]);
   assign write_txmode      = bus.write & (bus.addr[7:2] == LUMI_TXMODE[7:2]);
   assign write_rxmode      = bus.write & (bus.addr[7:2] == LUMI_RXMODE[7:2]);
   assign write_crdt_init   = bus.write & (bus.addr[7:2] == LUMI_CRDTINIT[7:2]);
   assign write_crdt_intrvl = bus.write & (bus.addr[7:2] == LUMI_CRDTINTRVL[7:2]);

   //##############################
   // control registers
   //##############################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         ctrl_reg <= '0;
      else if (write_ctrl)
         ctrl_reg <= bus.wdata;
   end

   // link comes up with no sw sequence, modes load from the phy on the rise
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         txmode_reg <= '0;
      else if (linkactive_rise)
         txmode_reg <= {8'h00, phy_iow, 8'h00, 4'b0001, 4'b0001};   // width, crdt en, tx en
      else if (write_txmode)
         txmode_reg <= bus.wdata;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rxmode_reg <= '0;
      else if (linkactive_rise)
         rxmode_reg <= {8'h00, phy_iow, 12'h000, 4'b0001};   // width, rx en
      else if (write_rxmode)
         rxmode_reg <= bus.wdata;
   end

   // wider pads mean fewer, bigger credits
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         crdt_init_reg <= '0;
      else if (linkactive_rise)
         crdt_init_reg <= {TOT_CRDT >> phy_iow, TOT_CRDT >> phy_iow};
      else if (write_crdt_init)
         crdt_init_reg <= bus.wdata;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         crdt_intrvl_reg <= CRDT_INTRVL_RST;
      else if (write_crdt_intrvl)
         crdt_intrvl_reg <= bus.wdata[15:0];
   end

   // csr outputs
   assign csr_arbmode          = ctrl_reg[5:4];
   assign csr_txen             = linkactive & txmode_reg[0];   // off while link down
   assign csr_txcrdt_en        = txmode_reg[4];
   assign csr_txiowidth        = txmode_reg[23:16];
   assign csr_rxen             = linkactive & rxmode_reg[0];
   assign csr_rxiowidth        = rxmode_reg[23:16];
   assign csr_txcrdt_intrvl    = crdt_intrvl_reg;
   assign csr_rxcrdt_req_init  = crdt_init_reg[15:0];
   assign csr_rxcrdt_resp_init = crdt_init_reg[31:16];

   //##############################
   // read mux
   //##############################
   always_comb
   begin
      case (bus.addr[7:2])
         LUMI_CTRL[7:2]          : bus.rdata = ctrl_reg;
         LUMI_STATUS[7:2]        : bus.rdata = {27'h0, linkactive, 4'h0};
         LUMI_TXMODE[7:2]        : bus.rdata = txmode_reg;
         LUMI_RXMODE[7:2]        : bus.rdata = rxmode_reg;
         LUMI_CRDTINIT[7:2]      : bus.rdata = crdt_init_reg;
         LUMI_CRDTINTRVL[7:2]    : bus.rdata = {16'h0000, crdt_intrvl_reg};
         LUMI_REQSTALLCYC[7:2]   : bus.rdata = req_stall_cycles;
         LUMI_RESPSTALLCYC[7:2]  : bus.rdata = resp_stall_cycles;
         LUMI_REQACTIVECYC[7:2]  : bus.rdata = req_active_cycles;
         LUMI_RESPACTIVECYC[7:2] : bus.rdata = resp_active_cycles;
         default                 : bus.rdata = '0;   // unmapped
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/lumi_ctrl_top.sv
`default_nettype none

module lumi_ctrl_top
   import lumi_pkg::*;
(
   input  wire            clk,
   input  wire            nreset,
   // register request
   input  wire            req_valid,
   input  wire            req_write,
   input  wire reg_addr_t req_addr,
   input  wire reg_data_t req_wdata,
   output logic           req_ready,
   // register response
   output logic           resp_valid,
   output reg_data_t      resp_data,
   input  wire            resp_ready,
   // link status
   input  wire            devicemode,
   input  wire            deviceready,
   input  wire            phy_linkactive,
   input  wire iow_t      phy_iow,
   // credit monitor taps
   input  wire            req_pending,
   input  wire            req_crdt_avail,
   input  wire            resp_pending,
   input  wire            resp_crdt_avail,
   // controls
   output logic           host_linkactive,
   output arbmode_t       csr_arbmode,
   output logic           csr_txen,
   output logic           csr_txcrdt_en,
   output logic           csr_rxen,
   output iow_t           csr_txiowidth,
   output iow_t           csr_rxiowidth,
   output crdt_t          csr_txcrdt_intrvl,
   output crdt_t          csr_rxcrdt_req_init,
   output crdt_t          csr_rxcrdt_resp_init
);

   cycles_t req_stall_cycles;
   cycles_t req_active_cycles;
   cycles_t resp_stall_cycles;
   cycles_t resp_active_cycles;

   lumi_reg_bus_if i_bus ();

   // external port to bus strobes
   lumi_regif i_regif (
      .clk        (clk),
      .nreset     (nreset),
      .req_valid  (req_valid),
      .req_write  (req_write),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp_data  (resp_data),
      .resp_ready (resp_ready),
      .bus        (i_bus.host)
   );

   // request class
   lumi_crdt_monitor i_req_monitor (
      .clk           (clk),
      .nreset        (nreset),
      .pending       (req_pending),
      .crdt_avail    (req_crdt_avail),
      .enable        (csr_txen),
      .stall_cycles  (req_stall_cycles),
      .active_cycles (req_active_cycles)
   );

   // response class
   lumi_crdt_monitor i_resp_monitor (
      .clk           (clk),
      .nreset        (nreset),
      .pending       (resp_pending),
      .crdt_avail    (resp_crdt_avail),
      .enable        (csr_txen),
      .stall_cycles  (resp_stall_cycles),
      .active_cycles (resp_active_cycles)
   );

   lumi_regs i_regs (
      .clk                  (clk),
      .nreset               (nreset),
      .devicemode           (devicemode),
      .deviceready          (deviceready),
      .phy_linkactive       (phy_linkactive),
      .phy_iow              (phy_iow),
      .bus                  (i_bus.target),
      .req_stall_cycles     (req_stall_cycles),
      .resp_stall_cycles    (resp_stall_cycles),
      .req_active_cycles    (req_active_cycles),
      .resp_active_cycles   (resp_active_cycles),
      .host_linkactive      (host_linkactive),
      .csr_arbmode          (csr_arbmode),
      .csr_txen             (csr_txen),
      .csr_txcrdt_en        (csr_txcrdt_en),
      .csr_rxen             (csr_rxen),
      .csr_txiowidth        (csr_txiowidth),
      .csr_rxiowidth        (csr_rxiowidth),
      .csr_txcrdt_intrvl    (csr_txcrdt_intrvl),
      .csr_rxcrdt_req_init  (csr_rxcrdt_req_init),
      .csr_rxcrdt_resp_init (csr_rxcrdt_resp_init)
   );

endmodule

`default_nettype wire

//--- sim/tb_lumi_ctrl.sv
`default_nettype none

module tb_lumi_ctrl
   import lumi_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   typedef enum {OP_WR, OP_RD, OP_PHY, OP_BURST, OP_HOLD, OP_CSR} op_e;

   typedef struct {
      string     name;
      op_e       op;
      reg_addr_t addr;
      reg_data_t data;       // write data, phy state or burst length
      reg_data_t expected;   // literal read value
      logic      use_model;  // take the read value from the model instead
   } test_t;

   // dut ports
   logic      clk;
   logic      nreset;
   logic      req_valid;
   logic      req_write;
   reg_addr_t req_addr;
   reg_data_t req_wdata;
   logic      req_ready;
   logic      resp_valid;
   reg_data_t resp_data;
   logic      resp_ready;
   logic      devicemode;
   logic      deviceready;
   logic      phy_linkactive;
   iow_t      phy_iow;
   logic      req_pending;
   logic      req_crdt_avail;
   logic      resp_pending;
   logic      resp_crdt_avail;
   logic      host_linkactive;
   arbmode_t  csr_arbmode;
   logic      csr_txen;
   logic      csr_txcrdt_en;
   logic      csr_rxen;
   iow_t      csr_txiowidth;
   iow_t      csr_rxiowidth;
   crdt_t     csr_txcrdt_intrvl;
   crdt_t     csr_rxcrdt_req_init;
   crdt_t     csr_rxcrdt_resp_init;

   test_t       tests[$];
   logic        table_ready = 1'b0;
   logic [15:0] lfsr_state  = 16'd27;

   // reference model state
   reg_data_t m_ctrl;
   reg_data_t m_txmode;
   reg_data_t m_rxmode;
   reg_data_t m_crdtinit;      // {resp, req}
   crdt_t     m_intrvl;
   logic      m_link;
   cycles_t   m_cnt[4];        // req stall, resp stall, req active, resp active

   lumi_ctrl_top i_lumi_ctrl_top (.*);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   //##############################
   // checks
   //##############################
   task automatic end_with_errors();
      $display("Finished with errors");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
         end_with_errors();
      end
   endtask

   task automatic check_cycles(input string name, input cycles_t exp, input cycles_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %0d cycles, actual %0d cycles", name, exp, act);
         end_with_errors();
      end
   endtask

   task automatic check_iow(input string name, input iow_t exp, input iow_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected 0x%02h, actual 0x%02h", name, exp, act);
         end_with_errors();
      end
   endtask

   task automatic check_crdt(input string name, input crdt_t exp, input crdt_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
         end_with_errors();
      end
   endtask

   task automatic check_arbmode(input string name, input arbmode_t exp, input arbmode_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
         end_with_errors();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
         end_with_errors();
      end
   endtask

   //##############################
   // reference model
   //##############################
   function automatic logic is_count(input reg_addr_t addr);
      return (addr >= LUMI_REQSTALLCYC) && (addr <= LUMI_RESPACTIVECYC);
   endfunction

   function automatic reg_data_t model_read(input reg_addr_t addr);
      case (addr[7:2])
         LUMI_CTRL[7:2]       : return m_ctrl;
         LUMI_STATUS[7:2]     : return {27'h0, m_link, 4'h0};   // link in bit 4
         LUMI_TXMODE[7:2]     : return m_txmode;
         LUMI_RXMODE[7:2]     : return m_rxmode;
         LUMI_CRDTINIT[7:2]   : return m_crdtinit;
         LUMI_CRDTINTRVL[7:2] : return {16'h0, m_intrvl};
         default              : return is_count(addr) ? m_cnt[(addr - LUMI_REQSTALLCYC) >> 2] : '0;
      endcase
   endfunction

   function automatic void model_write(input reg_addr_t addr, input reg_data_t data);
      case (addr[7:2])
         LUMI_CTRL[7:2]       : m_ctrl = data;
         LUMI_TXMODE[7:2]     : m_txmode = data;
         LUMI_RXMODE[7:2]     : m_rxmode = data;
         LUMI_CRDTINIT[7:2]   : m_crdtinit = data;
         LUMI_CRDTINTRVL[7:2] : m_intrvl = data[15:0];
         default              : ;   // status and counts ignore writes
      endcase
   endfunction

   // link follows the phy only when the device side is ready
   function automatic void model_phy(input logic dm, input logic dr, input logic pl,
                                     input iow_t iow);
      if (!dm || dr)
      begin
         if (pl && !m_link)
         begin
            m_txmode   = {8'h00, iow, 16'h0011};
            m_rxmode   = {8'h00, iow, 16'h0001};
            m_crdtinit = {16'(40 >> iow), 16'(40 >> iow)};
         end
         m_link = pl;
      end
   endfunction

   function automatic logic model_txen();
      return m_link & m_txmode[0];
   endfunction

   function automatic void count_cycle(input int idx);
      if (m_cnt[idx] != '1)
         m_cnt[idx] = m_cnt[idx] + 1;   // saturates
   endfunction

   // fibonacci lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic rand_bit();
      logic fb;
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   //##############################
   // bus access
   //##############################
   // called on a falling edge and returns one cycle after acceptance
   task automatic send_request(input logic wr, input reg_addr_t addr, input reg_data_t data);
      req_valid = 1'b1;
      req_write = wr;
      req_addr  = addr;
      req_wdata = data;
      while (!req_ready)
         @(negedge clk);
      @(negedge clk);   // handshake on the edge in between
      req_valid = 1'b0;
   endtask

   task automatic wait_response(output reg_data_t data);
      while (!resp_valid)
         @(negedge clk);
      data = resp_data;
      @(negedge clk);   // taken since resp_ready is high
   endtask

   task automatic check_read(input string name, input reg_addr_t addr, input reg_data_t exp,
                             input reg_data_t act);
      if (is_count(addr))
         check_cycles(name, cycles_t'(exp), cycles_t'(act));
      else
         check_data(name, exp, act);
   endtask

   task automatic check_csr(input string name);
      check_bit({name, " host_linkactive"}, m_link, host_linkactive);
      check_arbmode({name, " arbmode"}, m_ctrl[5:4], csr_arbmode);
      check_bit({name, " txen"}, model_txen(), csr_txen);
      check_bit({name, " txcrdt_en"}, m_txmode[4], csr_txcrdt_en);
      check_bit({name, " rxen"}, m_link & m_rxmode[0], csr_rxen);
      check_iow({name, " txiowidth"}, m_txmode[23:16], csr_txiowidth);
      check_iow({name, " rxiowidth"}, m_rxmode[23:16], csr_rxiowidth);
      check_crdt({name, " intrvl"}, m_intrvl, csr_txcrdt_intrvl);
      check_crdt({name, " req_init"}, m_crdtinit[15:0], csr_rxcrdt_req_init);
      check_crdt({name, " resp_init"}, m_crdtinit[31:16], csr_rxcrdt_resp_init);
   endtask

   // held response with a second read to status waiting behind it
   task automatic check_hold(input string name, input reg_addr_t addr, input reg_data_t exp);
      reg_data_t held;
      reg_data_t rd;
      resp_ready = 1'b0;
      send_request(1'b0, addr, '0);
      while (!resp_valid)
         @(negedge clk);
      held = resp_data;
      check_read(name, addr, exp, held);
      req_valid = 1'b1;
      req_write = 1'b0;
      req_addr  = LUMI_STATUS;   // other data if it slipped in
      repeat (4)
      begin
         @(negedge clk);
         check_bit({name, " resp_valid held"}, 1'b1, resp_valid);
         check_data({name, " resp_data held"}, held, resp_data);
         check_bit({name, " req_ready low"}, 1'b0, req_ready);
      end
      resp_ready = 1'b1;
      send_request(1'b0, LUMI_STATUS, '0);   // goes once the held one is taken
      wait_response(rd);
      check_data({name, " next"}, model_read(LUMI_STATUS), rd);
   endtask

   //##############################
   // table
   //##############################
   task automatic add_test(input string name, input op_e op, input reg_addr_t addr,
                           input reg_data_t data, input reg_data_t expected,
                           input logic use_model);
      test_t t;
      t.name      = name;
      t.op        = op;
      t.addr      = addr;
      t.data      = data;
      t.expected  = expected;
      t.use_model = use_model;
      tests.push_back(t);
   endtask

   task automatic build_table();
      add_test("rst ctrl", OP_RD, LUMI_CTRL, '0, 32'h0, 1'b0);
      add_test("rst status", OP_RD, LUMI_STATUS, '0, 32'h0, 1'b0);
      add_test("rst txmode", OP_RD, LUMI_TXMODE, '0, 32'h0, 1'b0);
      add_test("rst rxmode", OP_RD, LUMI_RXMODE, '0, 32'h0, 1'b0);
      add_test("rst crdtinit", OP_RD, LUMI_CRDTINIT, '0, 32'h0, 1'b0);
      add_test("rst crdtintrvl", OP_RD, LUMI_CRDTINTRVL, '0, 32'h10, 1'b0);
      add_test("rst reqstall", OP_RD, LUMI_REQSTALLCYC, '0, 32'h0, 1'b0);
      add_test("rst respstall", OP_RD, LUMI_RESPSTALLCYC, '0, 32'h0, 1'b0);
      add_test("rst reqactive", OP_RD, LUMI_REQACTIVECYC, '0, 32'h0, 1'b0);
      add_test("rst respactive", OP_RD, LUMI_RESPACTIVECYC, '0, 32'h0, 1'b0);
      add_test("rst unmapped 28", OP_RD, 8'h28, '0, 32'h0, 1'b0);
      add_test("rst unmapped fc", OP_RD, 8'hFC, '0, 32'h0, 1'b0);
      add_test("rst csr", OP_CSR, '0, '0, '0, 1'b1);
      // data[10:8] = {devicemode, deviceready, phy_linkactive}, data[7:0] = pad width
      add_test("gated phy", OP_PHY, '0, 32'h0502, '0, 1'b1);
      add_test("gated status", OP_RD, LUMI_STATUS, '0, 32'h0, 1'b0);
      add_test("gated txmode", OP_RD, LUMI_TXMODE, '0, 32'h0, 1'b0);
      add_test("gated csr", OP_CSR, '0, '0, '0, 1'b1);
      add_test("link up phy", OP_PHY, '0, 32'h0702, '0, 1'b1);
      add_test("link status", OP_RD, LUMI_STATUS, '0, 32'h10, 1'b0);
      add_test("link txmode", OP_RD, LUMI_TXMODE, '0, 32'h0002_0011, 1'b0);
      add_test("link rxmode", OP_RD, LUMI_RXMODE, '0, 32'h0002_0001, 1'b0);
      add_test("link crdtinit", OP_RD, LUMI_CRDTINIT, '0, 32'h000A_000A, 1'b0);
      add_test("link csr", OP_CSR, '0, '0, '0, 1'b1);
      add_test("wr ctrl", OP_WR, LUMI_CTRL, 32'h30, '0, 1'b1);
      add_test("rd ctrl", OP_RD, LUMI_CTRL, '0, 32'h30, 1'b0);
      add_test("wr crdtinit", OP_WR, LUMI_CRDTINIT, 32'h0007_0005, '0, 1'b1);
      add_test("wr crdtintrvl", OP_WR, LUMI_CRDTINTRVL, 32'h20, '0, 1'b1);
      add_test("rd crdtintrvl", OP_RD, LUMI_CRDTINTRVL, '0, 32'h20, 1'b0);
      add_test("wr status", OP_WR, LUMI_STATUS, 32'hFFFF_FFFF, '0, 1'b1);
      add_test("rd status", OP_RD, LUMI_STATUS, '0, 32'h10, 1'b0);
      add_test("wr csr", OP_CSR, '0, '0, '0, 1'b1);
      add_test("tx off", OP_WR, LUMI_TXMODE, 32'h0002_0010, '0, 1'b1);
      add_test("tx off csr", OP_CSR, '0, '0, '0, 1'b1);
      add_test("tx on", OP_WR, LUMI_TXMODE, 32'h0002_0011, '0, 1'b1);
      add_test("burst a", OP_BURST, '0, 32'd32, '0, 1'b1);
      add_test("burst b", OP_BURST, '0, 32'd24, '0, 1'b1);
      add_test("mon reqstall", OP_RD, LUMI_REQSTALLCYC, '0, '0, 1'b1);
      add_test("mon respstall", OP_RD, LUMI_RESPSTALLCYC, '0, '0, 1'b1);
      add_test("mon reqactive", OP_RD, LUMI_REQACTIVECYC, '0, '0, 1'b1);
      add_test("mon respactive", OP_RD, LUMI_RESPACTIVECYC, '0, '0, 1'b1);
      add_test("tx off again", OP_WR, LUMI_TXMODE, 32'h0002_0010, '0, 1'b1);
      add_test("burst off", OP_BURST, '0, 32'd20, '0, 1'b1);
      add_test("off reqstall", OP_RD, LUMI_REQSTALLCYC, '0, '0, 1'b1);
      add_test("off respstall", OP_RD, LUMI_RESPSTALLCYC, '0, '0, 1'b1);
      add_test("off reqactive", OP_RD, LUMI_REQACTIVECYC, '0, '0, 1'b1);
      add_test("off respactive", OP_RD, LUMI_RESPACTIVECYC, '0, '0, 1'b1);
      add_test("hold crdtinit", OP_HOLD, LUMI_CRDTINIT, '0, 32'h0007_0005, 1'b0);
      add_test("end csr", OP_CSR, '0, '0, '0, 1'b1);
   endtask

   task automatic run_entry(input test_t t);
      reg_data_t exp;
      reg_data_t rd;
      exp = t.use_model ? model_read(t.addr) : t.expected;
      case (t.op)
         OP_WR :
         begin
            send_request(1'b1, t.addr, t.data);
            @(negedge clk);   // write lands one edge after acceptance
            model_write(t.addr, t.data);
         end
         OP_RD :
         begin
            send_request(1'b0, t.addr, '0);
            wait_response(rd);
            check_read(t.name, t.addr, exp, rd);
         end
         OP_PHY :
         begin
            devicemode     = t.data[10];
            deviceready    = t.data[9];
            phy_linkactive = t.data[8];
            phy_iow        = t.data[7:0];
            repeat (5) @(negedge clk);   // link, rise, then load
            model_phy(t.data[10], t.data[9], t.data[8], t.data[7:0]);
         end
         OP_BURST :
         begin
            for (int i = 0; i < t.data; i++)
            begin
               req_pending     = rand_bit();
               req_crdt_avail  = rand_bit();
               resp_pending    = rand_bit();
               resp_crdt_avail = rand_bit();
               if (model_txen())
               begin
                  if (req_pending)
                     count_cycle(req_crdt_avail ? 2 : 0);
                  if (resp_pending)
                     count_cycle(resp_crdt_avail ? 3 : 1);
               end
               @(negedge clk);
            end
            req_pending  = 1'b0;
            resp_pending = 1'b0;
            @(negedge clk);   // last count settles
         end
         OP_HOLD :
            check_hold(t.name, t.addr, exp);
         OP_CSR :
            check_csr(t.name);
         default : ;
      endcase
   endtask

   //##############################
   // main sequence
   //##############################
   initial
   begin
      nreset          = 1'b0;
      req_valid       = 1'b0;
      req_write       = 1'b0;
      req_addr        = '0;
      req_wdata       = '0;
      resp_ready      = 1'b1;
      devicemode      = 1'b0;
      deviceready     = 1'b0;
      phy_linkactive  = 1'b0;
      phy_iow         = '0;
      req_pending     = 1'b0;
      req_crdt_avail  = 1'b0;
      resp_pending    = 1'b0;
      resp_crdt_avail = 1'b0;
      m_ctrl          = '0;
      m_txmode        = '0;
      m_rxmode        = '0;
      m_crdtinit      = '0;
      m_intrvl        = 16'd16;
      m_link          = 1'b0;
      foreach (m_cnt[k])
         m_cnt[k] = '0;
      build_table();
      table_ready = 1'b1;
      repeat (2) @(posedge clk);   // reset for 2 cycles
      @(negedge clk);
      nreset = 1'b1;
      @(negedge clk);
      foreach (tests[i])
         run_entry(tests[i]);
      $display("Finished with no errors");
      $finish;
   end

   // watchdog allows 64 cycles per table entry
   initial
   begin
      wait (table_ready);
      repeat (tests.size() * 64) @(posedge clk);
      $display("timeout: the tests did not complete within %0d cycles", tests.size() * 64);
      end_with_errors();
   end

endmodule

`default_nettype wire

//--- verilog.f
hdl/lumi_pkg.sv
hdl/lumi_reg_bus_if.sv
hdl/lumi_regif.sv
hdl/lumi_crdt_monitor.sv
hdl/lumi_regs.sv
hdl/lumi_ctrl_top.sv
sim/tb_lumi_ctrl.sv

//--- Bender.yml
package:
  name: lumi_ctrl

sources:
  - hdl/lumi_pkg.sv
  - hdl/lumi_reg_bus_if.sv
  - hdl/lumi_regif.sv
  - hdl/lumi_crdt_monitor.sv
  - hdl/lumi_regs.sv
  - hdl/lumi_ctrl_top.sv
  - target: simulation
    files:
      - sim/tb_lumi_ctrl.sv
